/* hdl/pipe_consts.svh */
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// Instruction field bit ranges
`define OP_F        31:26
`define RS_F        25:21
`define RT_F        20:16
`define RD_F        15:11
`define FUNCT_F     5:0

// Primary opcodes
`define OP_SPECIAL  6'h00
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// Funct codes under OP_SPECIAL
`define FUNCT_JR    6'h08
`define FUNCT_JALR  6'h09
`define FUNCT_ADDU  6'h21
`define FUNCT_SUBU  6'h23

// Link register written by jal
`define RA_REG      5'd31

// Fetch address after reset and per-instruction step
`define RESET_PC    32'h0000_3000
`define PC_STEP     32'd4

`endif

/* hdl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // One instruction word
    typedef logic [31:0] instr_t;

    // Register file index
    typedef logic [4:0] reg_num_t;

    // Byte address of an instruction
    typedef logic [31:0] addr_t;

    // D/E operand select
    // 0 regfile, 1 M alu result, 2 W result, 3 M link, 4 W link
    typedef logic [2:0] fwd_sel_t;

    // M store data select
    // 0 none, 1 W result, 2 W link
    typedef logic [1:0] fwd_m_sel_t;

endpackage : pipe_pkg

`default_nettype wire

/* hdl/instr_classify.sv */
`default_nettype none

`include "pipe_consts.svh"

module instr_classify (
    input  pipe_pkg::instr_t   ir,
    output logic               is_b,
    output logic               is_cal_r,
    output logic               is_cal_i,
    output logic               is_load,
    output logic               is_store,
    output logic               is_jal,
    output logic               is_jr,
    output logic               is_jalr,
    output pipe_pkg::reg_num_t dst
);
    import pipe_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_num_t   rt_f;
    reg_num_t   rd_f;

    assign opcode = ir[`OP_F];
    assign funct  = ir[`FUNCT_F];
    assign rt_f   = ir[`RT_F];
    assign rd_f   = ir[`RD_F];

    // Unknown words, including the all-zero nop, fall through with no class
    always_comb begin
        is_b     = 1'b0;
        is_cal_r = 1'b0;
        is_cal_i = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_jal   = 1'b0;
        is_jr    = 1'b0;
        is_jalr  = 1'b0;
        dst      = '0;
        case (opcode)
            `OP_SPECIAL: begin
                case (funct)
                    `FUNCT_ADDU, `FUNCT_SUBU: begin
                        is_cal_r = 1'b1;
                        dst      = rd_f;
                    end
                    `FUNCT_JR: begin
                        is_jr = 1'b1;
                    end
                    `FUNCT_JALR: begin
                        is_jalr = 1'b1;
                        dst     = rd_f;
                    end
                    default: begin
                        dst = '0;
                    end
                endcase
            end
            `OP_ORI, `OP_LUI: begin
                is_cal_i = 1'b1;
                dst      = rt_f;
            end
            `OP_LW: begin
                is_load = 1'b1;
                dst     = rt_f;
            end
            `OP_SW:  is_store = 1'b1;
            `OP_BEQ: is_b     = 1'b1;
            `OP_JAL: begin
                is_jal = 1'b1;
                dst    = `RA_REG;
            end
            default: begin
                dst = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/hazard_unit.sv */
`default_nettype none

`include "pipe_consts.svh"

module hazard_unit (
    input  pipe_pkg::instr_t     ir_d,
    input  pipe_pkg::instr_t     ir_e,
    input  pipe_pkg::instr_t     ir_m,
    input  pipe_pkg::instr_t     ir_w,
    output logic                 stall,
    output logic                 pc_en,
    output logic                 if_id_en,
    output logic                 id_ex_clr,
    output pipe_pkg::fwd_sel_t   fwd_rs_d,
    output pipe_pkg::fwd_sel_t   fwd_rt_d,
    output pipe_pkg::fwd_sel_t   fwd_rs_e,
    output pipe_pkg::fwd_sel_t   fwd_rt_e,
    output pipe_pkg::fwd_m_sel_t fwd_rt_m
);
    import pipe_pkg::*;

    logic b_d, cal_r_d, cal_i_d, load_d, store_d, jr_d, jalr_d;
    logic cal_r_e, cal_i_e, load_e, store_e;
    logic cal_r_m, cal_i_m, load_m, store_m, jal_m, jalr_m;
    logic cal_r_w, cal_i_w, load_w, jal_w, jalr_w;
    reg_num_t dst_e, dst_m, dst_w;

    reg_num_t d_rs, d_rt, e_rs, e_rt, m_rt;
    logic d_jump_reg, d_alu_mem, e_alu_mem, e_wr;
    logic m_alu, m_link, w_res, w_link;
    logic stall_b, stall_jr, stall_load;

    instr_classify d_cls (
        .ir(ir_d), .is_b(b_d), .is_cal_r(cal_r_d), .is_cal_i(cal_i_d),
        .is_load(load_d), .is_store(store_d), .is_jal(), .is_jr(jr_d),
        .is_jalr(jalr_d), .dst()
    );

    instr_classify e_cls (
        .ir(ir_e), .is_b(), .is_cal_r(cal_r_e), .is_cal_i(cal_i_e),
        .is_load(load_e), .is_store(store_e), .is_jal(), .is_jr(),
        .is_jalr(), .dst(dst_e)
    );

    instr_classify m_cls (
        .ir(ir_m), .is_b(), .is_cal_r(cal_r_m), .is_cal_i(cal_i_m),
        .is_load(load_m), .is_store(store_m), .is_jal(jal_m), .is_jr(),
        .is_jalr(jalr_m), .dst(dst_m)
    );

    instr_classify w_cls (
        .ir(ir_w), .is_b(), .is_cal_r(cal_r_w), .is_cal_i(cal_i_w),
        .is_load(load_w), .is_store(), .is_jal(jal_w), .is_jr(),
        .is_jalr(jalr_w), .dst(dst_w)
    );

    assign d_rs = ir_d[`RS_F];
    assign d_rt = ir_d[`RT_F];
    assign e_rs = ir_e[`RS_F];
    assign e_rt = ir_e[`RT_F];
    assign m_rt = ir_m[`RT_F];

    assign d_jump_reg = jr_d | jalr_d;
    assign d_alu_mem  = cal_r_d | cal_i_d | load_d | store_d;
    assign e_alu_mem  = cal_r_e | cal_i_e | load_e | store_e;
    assign e_wr       = cal_r_e | cal_i_e | load_e;
    assign m_alu      = cal_r_m | cal_i_m;
    assign m_link     = jal_m | jalr_m;
    assign w_res      = cal_r_w | cal_i_w | load_w;
    assign w_link     = jal_w | jalr_w;

    // Register zero is never a dependency
    function automatic logic hits(input reg_num_t src, input reg_num_t dst);
        return (src != '0) && (src == dst);
    endfunction

    // M sources win over W and alu results win over links
    function automatic fwd_sel_t pick_fwd(
        input logic     use_m,
        input logic     use_w,
        input reg_num_t src,
        input logic     alu_m,
        input logic     link_m,
        input reg_num_t wr_m,
        input logic     res_w,
        input logic     link_w,
        input reg_num_t wr_w
    );
        fwd_sel_t sel;
        sel = 3'd0;
        if (use_m && alu_m && hits(src, wr_m)) begin
            sel = 3'd1;
        end else if (use_m && link_m && hits(src, wr_m)) begin
            sel = 3'd3;
        end else if (use_w && res_w && hits(src, wr_w)) begin
            sel = 3'd2;
        end else if (use_w && link_w && hits(src, wr_w)) begin
            sel = 3'd4;
        end
        return sel;
    endfunction

    // Branch compares in D, so a result still in E or a load in M is too late
    assign stall_b = b_d &&
        ((e_wr && (hits(d_rs, dst_e) || hits(d_rt, dst_e))) ||
         (load_m && (hits(d_rs, dst_m) || hits(d_rt, dst_m))));

    assign stall_jr = d_jump_reg &&
        ((e_wr && hits(d_rs, dst_e)) || (load_m && hits(d_rs, dst_m)));

    // Load-use hazard on rs and on the rt of an R-type
    // Store data is fixed up later in M
    assign stall_load = load_e &&
        ((d_alu_mem && hits(d_rs, dst_e)) || (cal_r_d && hits(d_rt, dst_e)));

    assign stall     = stall_b | stall_jr | stall_load;
    assign pc_en     = ~stall;
    assign if_id_en  = ~stall;
    assign id_ex_clr = stall;

    assign fwd_rs_d = pick_fwd(b_d | d_jump_reg, b_d | d_jump_reg, d_rs,
                               m_alu, m_link, dst_m, w_res, w_link, dst_w);
    assign fwd_rt_d = pick_fwd(b_d, b_d, d_rt,
                               m_alu, m_link, dst_m, w_res, w_link, dst_w);
    assign fwd_rs_e = pick_fwd(e_alu_mem, e_alu_mem, e_rs,
                               m_alu, m_link, dst_m, w_res, w_link, dst_w);
    // A store in E takes rt from W here, or later from fwd_rt_m
    assign fwd_rt_e = pick_fwd(cal_r_e, cal_r_e | store_e, e_rt,
                               m_alu, m_link, dst_m, w_res, w_link, dst_w);

    always_comb begin
        fwd_rt_m = 2'd0;
        if (store_m && w_res && hits(m_rt, dst_w)) begin
            fwd_rt_m = 2'd1;
        end else if (store_m && w_link && hits(m_rt, dst_w)) begin
            fwd_rt_m = 2'd2;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_pc.sv */
`default_nettype none

`include "pipe_consts.svh"

module fetch_pc (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pc_en,
    output pipe_pkg::addr_t pc
);
    import pipe_pkg::*;

    addr_t pc_next;

    // Sequential fetch only
    assign pc_next = pc + `PC_STEP;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/stage_regs.sv */
`default_nettype none

module stage_regs (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             if_id_en,
    input  logic             id_ex_clr,
    input  pipe_pkg::instr_t instr,
    output pipe_pkg::instr_t ir_d,
    output pipe_pkg::instr_t ir_e,
    output pipe_pkg::instr_t ir_m,
    output pipe_pkg::instr_t ir_w
);
    import pipe_pkg::*;

    instr_t ir_e_in;

    // A cleared E stage carries the all-zero nop
    assign ir_e_in = id_ex_clr ? '0 : ir_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_d <= '0;
        end else if (if_id_en) begin
            ir_d <= instr;
        end
    end

    // E, M and W always advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_e <= '0;
            ir_m <= '0;
            ir_w <= '0;
        end else begin
            ir_e <= ir_e_in;
            ir_m <= ir_e;
            ir_w <= ir_m;
        end
    end

endmodule

`default_nettype wire

/* hdl/pipe_ctrl_top.sv */
`default_nettype none

module pipe_ctrl_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pipe_pkg::instr_t     instr,
    output pipe_pkg::addr_t      pc,
    output logic                 stall,
    output pipe_pkg::fwd_sel_t   fwd_rs_d,
    output pipe_pkg::fwd_sel_t   fwd_rt_d,
    output pipe_pkg::fwd_sel_t   fwd_rs_e,
    output pipe_pkg::fwd_sel_t   fwd_rt_e,
    output pipe_pkg::fwd_m_sel_t fwd_rt_m,
    output pipe_pkg::instr_t     ir_e,
    output pipe_pkg::instr_t     ir_m,
    output pipe_pkg::instr_t     ir_w
);

    logic             pc_en;
    logic             if_id_en;
    logic             id_ex_clr;
    pipe_pkg::instr_t ir_d;

    fetch_pc fetch_pc_i (
        .clk   (clk),
        .rst_n (rst_n),
        .pc_en (pc_en),
        .pc    (pc)
    );

    stage_regs stage_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .if_id_en  (if_id_en),
        .id_ex_clr (id_ex_clr),
        .instr     (instr),
        .ir_d      (ir_d),
        .ir_e      (ir_e),
        .ir_m      (ir_m),
        .ir_w      (ir_w)
    );

    hazard_unit hazard_unit_i (
        .ir_d      (ir_d),
        .ir_e      (ir_e),
        .ir_m      (ir_m),
        .ir_w      (ir_w),
        .stall     (stall),
        .pc_en     (pc_en),
        .if_id_en  (if_id_en),
        .id_ex_clr (id_ex_clr),
        .fwd_rs_d  (fwd_rs_d),
        .fwd_rt_d  (fwd_rt_d),
        .fwd_rs_e  (fwd_rs_e),
        .fwd_rt_e  (fwd_rt_e),
        .fwd_rt_m  (fwd_rt_m)
    );

endmodule

`default_nettype wire

/* tests/pipe_ctrl_assert.sv */
`default_nettype none

module pipe_ctrl_assert (
    input logic             clk,
    input logic             rst_n,
    input logic             stall,
    input logic             id_ex_clr,
    input pipe_pkg::addr_t  pc,
    input pipe_pkg::instr_t ir_d,
    input pipe_pkg::instr_t ir_e
);

    int fail_count = 0;

    // Fetch side freezes for one edge per stall cycle
    pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> pc == $past(pc))
    else begin
        $error("pc moved on the edge after a stall");
        fail_count++;
    end

    ir_d_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> ir_d == $past(ir_d))
    else begin
        $error("IR_D changed on the edge after a stall");
        fail_count++;
    end

    // Bubble is the all-zero nop
    bubble_zero: assert property (@(posedge clk) disable iff (!rst_n)
        id_ex_clr |=> ir_e == '0)
    else begin
        $error("IR_E is not a nop after a bubble");
        fail_count++;
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !stall)
    else begin
        $error("stall raised while in reset");
        fail_count++;
    end

endmodule

bind pipe_ctrl_top pipe_ctrl_assert pipe_ctrl_assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .id_ex_clr (id_ex_clr),
    .pc        (pc),
    .ir_d      (ir_d),
    .ir_e      (ir_e)
);

`default_nettype wire

/* tests/tb_pipe_ctrl.sv */
`default_nettype none

`include "pipe_consts.svh"

module tb_pipe_ctrl;
    import pipe_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int TRACE_LEN    = 27;
    localparam int COLS         = 7;
    localparam int TIMEOUT      = (TRACE_LEN + 20) * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    instr_t     instr;
    addr_t      pc;
    logic       stall;
    fwd_sel_t   fwd_rs_d;
    fwd_sel_t   fwd_rt_d;
    fwd_sel_t   fwd_rs_e;
    fwd_sel_t   fwd_rt_e;
    fwd_m_sel_t fwd_rt_m;
    instr_t     ir_e;
    instr_t     ir_m;
    instr_t     ir_w;

    // Seven words per trace line
    logic [31:0] trace_mem [0:255];

    // Reference copy of the stage registers, stepped with the traced stall
    instr_t      exp_d;
    instr_t      exp_e;
    instr_t      exp_m;
    instr_t      exp_w;
    int unsigned issued;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pipe_ctrl_top pipe_ctrl_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .pc       (pc),
        .stall    (stall),
        .fwd_rs_d (fwd_rs_d),
        .fwd_rt_d (fwd_rt_d),
        .fwd_rs_e (fwd_rs_e),
        .fwd_rt_e (fwd_rt_e),
        .fwd_rt_m (fwd_rt_m),
        .ir_e     (ir_e),
        .ir_m     (ir_m),
        .ir_w     (ir_w)
    );

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic expect_reset_state();
        compare_value("reset pc", pc, `RESET_PC);
        compare_value("reset stall", 32'(stall), 32'd0);
        compare_value("reset fwd_rs_d", 32'(fwd_rs_d), 32'd0);
        compare_value("reset fwd_rt_d", 32'(fwd_rt_d), 32'd0);
        compare_value("reset fwd_rs_e", 32'(fwd_rs_e), 32'd0);
        compare_value("reset fwd_rt_e", 32'(fwd_rt_e), 32'd0);
        compare_value("reset fwd_rt_m", 32'(fwd_rt_m), 32'd0);
    endtask

    task automatic score_cycle(input int k);
        logic [7:0] base;
        addr_t      exp_pc;
        base   = 8'(k * COLS);
        // Fetch only moves on cycles without a stall
        exp_pc = `RESET_PC + issued * 32'd4;
        compare_value($sformatf("line %0d pc", k), pc, exp_pc);
        compare_value($sformatf("line %0d stall", k), 32'(stall), trace_mem[base + 8'd1]);
        compare_value($sformatf("line %0d fwd_rs_d", k), 32'(fwd_rs_d), trace_mem[base + 8'd2]);
        compare_value($sformatf("line %0d fwd_rt_d", k), 32'(fwd_rt_d), trace_mem[base + 8'd3]);
        compare_value($sformatf("line %0d fwd_rs_e", k), 32'(fwd_rs_e), trace_mem[base + 8'd4]);
        compare_value($sformatf("line %0d fwd_rt_e", k), 32'(fwd_rt_e), trace_mem[base + 8'd5]);
        compare_value($sformatf("line %0d fwd_rt_m", k), 32'(fwd_rt_m), trace_mem[base + 8'd6]);
        compare_value($sformatf("line %0d ir_e", k), ir_e, exp_e);
        compare_value($sformatf("line %0d ir_m", k), ir_m, exp_m);
        compare_value($sformatf("line %0d ir_w", k), ir_w, exp_w);
    endtask

    task automatic advance_model(input logic stalled, input instr_t fetched);
        exp_w = exp_m;
        exp_m = exp_e;
        if (stalled) begin
            exp_e = '0;
        end else begin
            exp_e = exp_d;
            exp_d = fetched;
            issued++;
        end
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        instr  = '0;
        exp_d  = '0;
        exp_e  = '0;
        exp_m  = '0;
        exp_w  = '0;
        issued = 0;
        $readmemh("tests/pipe_trace.txt", trace_mem);
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        expect_reset_state();
        @(posedge clk);
        rst_n <= 1'b1;
        for (int k = 0; k < TRACE_LEN; k++) begin
            instr <= trace_mem[8'(k * COLS)];
            @(negedge clk);
            score_cycle(k);
            advance_model(trace_mem[8'(k * COLS + 1)][0], trace_mem[8'(k * COLS)]);
            @(posedge clk);
        end
        if (pipe_ctrl_top_i.pipe_ctrl_assert_i.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("The bound checker saw %0d assertion failures",
                     pipe_ctrl_top_i.pipe_ctrl_assert_i.fail_count);
            $display("sim failed");
            $fatal(1, "assertion failures");
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before the trace was played to the end");
        $display("sim failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* tests/pipe_trace.txt */
// One line per cycle after reset, all values hex
// instr stall fwd_rs_d fwd_rt_d fwd_rs_e fwd_rt_e fwd_rt_m
34010011 0 0 0 0 0 0
34020022 0 0 0 0 0 0
00221821 0 0 0 0 0 0
00612021 0 0 0 0 0 0
8c850000 0 0 0 2 1 0
00a33021 0 0 0 1 0 0
8c270004 1 0 0 1 0 0
8c270004 0 0 0 0 0 0
ac070008 0 0 0 2 0 0
10c70000 0 0 0 0 0 0
00440821 1 2 0 0 0 0
00440821 0 0 2 0 0 1
10200000 0 0 0 0 0 0
0c000c10 1 0 0 0 0 0
0c000c10 0 1 0 0 0 0
ac1f0000 0 0 0 0 0 0
03e00008 0 0 0 0 0 0
00604809 0 3 0 0 0 0
340a0001 0 0 0 0 0 2
01205821 0 0 0 0 0 0
34000007 0 0 0 0 0 0
00006821 0 0 0 4 0 0
00000000 0 0 0 0 0 0
00000000 0 0 0 0 0 0
00000000 0 0 0 0 0 0
00000000 0 0 0 0 0 0
00000000 0 0 0 0 0 0

/* project.f */
+incdir+hdl
hdl/pipe_pkg.sv
hdl/instr_classify.sv
hdl/hazard_unit.sv
hdl/fetch_pc.sv
hdl/stage_regs.sv
hdl/pipe_ctrl_top.sv
tests/pipe_ctrl_assert.sv
tests/tb_pipe_ctrl.sv

/* Makefile */
# Verilator build for the pipeline control testbench

VERILATOR ?= verilator
TOP       ?= tb_pipe_ctrl
SIM_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --assert
PASS_MSG  ?= sim passed

SIM_BIN = $(SIM_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILELIST)

# Success only when the pass line shows up in the simulator output
run: compile
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(SIM_DIR)
